/* sd_cmd_pkg.sv */
package sd_cmd_pkg;

    // ==================================================
    // CMD frame geometry
    // ==================================================
    localparam int CMD_BITS          = 48;
    localparam int PAYLOAD_BITS      = 40;
    localparam int CRC_BITS          = 7;
    localparam int TURNAROUND_CYCLES = 2;

    typedef logic [CMD_BITS-1:0] cmd_word_t;
    typedef logic [CRC_BITS-1:0] crc7_t;
    typedef logic [5:0]          bit_count_t;

    // x^7 + x^3 + 1, the x^7 term is implicit
    localparam crc7_t CRC7_POLY = 7'h09;

    typedef enum logic {
        RESP_NONE = 1'b0,
        RESP_48   = 1'b1
    } resp_type_t;

    // ==================================================
    // State machines
    // ==================================================
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_SEND,
        SEQ_SEND_DROP,
        SEQ_RECV,
        SEQ_RECV_DROP
    } seq_state_t;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PAYLOAD,
        TX_CRC,
        TX_STOP,
        TX_ACK
    } tx_state_t;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_TURN,
        RX_HUNT,
        RX_SHIFT,
        RX_ACK
    } rx_state_t;

endpackage

/* sd_xfer_if.sv */
`timescale 1ns/10ps

interface sd_xfer_if import sd_cmd_pkg::*; ();

    // Four-phase handshake
    logic req;
    logic ack;

    // Driven by the initiator for a send and by the engine for a receive
    wire cmd_word_t word;

    // Only meaningful while ack is high on a receive
    logic err;

    modport initiator (
        output req,
        input  ack,
        inout  word,
        input  err
    );

    modport engine (
        input  req,
        output ack,
        inout  word,
        output err
    );

endinterface

/* sd_crc7.sv */
`timescale 1ns/10ps

module sd_crc7 import sd_cmd_pkg::*; (
    input  logic  clk_fast,
    input  logic  clear,
    input  logic  enable,
    input  logic  data_bit,
    output crc7_t crc
);

    logic feedback;

    // Incoming bit meets the bit falling off the top
    assign feedback = crc[CRC_BITS-1] ^ data_bit;

    always_ff @(posedge clk_fast) begin
        if (clear) begin
            crc <= '0;
        end else if (enable) begin
            crc <= {crc[CRC_BITS-2:0], 1'b0} ^ (feedback ? CRC7_POLY : crc7_t'(0));
        end
    end

endmodule

/* sd_cmd_sender.sv */
`timescale 1ns/10ps

module sd_cmd_sender import sd_cmd_pkg::*; (
    input  logic      clk_fast,
    input  logic      init_resetPulse,
    sd_xfer_if.engine xfer,
    output logic      sd_cmd_out,
    output logic      sd_cmd_oe
);

    tx_state_t  state;
    bit_count_t cnt;
    cmd_word_t  shift_q;
    crc7_t      crc;
    logic [2:0] crc_idx;

    // CRC goes out MSB first
    assign crc_idx = 3'(CRC_BITS - 1) - cnt[2:0];

    // Nothing on the send path can fail
    assign xfer.err = 1'b0;

    // Remainder restarts every time the sender is idle
    sd_crc7 crc_i (
        .clk_fast (clk_fast),
        .clear    (state == TX_IDLE),
        .enable   (state == TX_PAYLOAD),
        .data_bit (shift_q[CMD_BITS-1]),
        .crc      (crc)
    );

    always_ff @(posedge clk_fast) begin
        if (state == TX_IDLE && xfer.req) begin
            shift_q <= xfer.word;
        end else if (state == TX_PAYLOAD) begin
            shift_q <= {shift_q[CMD_BITS-2:0], 1'b0};
        end
    end

    // ==================================================
    // Line FSM, outputs registered so oe is glitch free
    // ==================================================
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state      <= TX_IDLE;
            cnt        <= '0;
            xfer.ack   <= 1'b0;
            sd_cmd_out <= 1'b0;
            sd_cmd_oe  <= 1'b0;
        end else begin
            case (state)
            TX_IDLE: begin
                if (xfer.req) begin
                    cnt   <= '0;
                    state <= TX_PAYLOAD;
                end
            end
            TX_PAYLOAD: begin
                sd_cmd_out <= shift_q[CMD_BITS-1];
                sd_cmd_oe  <= 1'b1;
                cnt        <= cnt + bit_count_t'(1);
                if (cnt == bit_count_t'(PAYLOAD_BITS - 1)) begin
                    cnt   <= '0;
                    state <= TX_CRC;
                end
            end
            TX_CRC: begin
                sd_cmd_out <= crc[crc_idx];
                cnt        <= cnt + bit_count_t'(1);
                if (cnt == bit_count_t'(CRC_BITS - 1)) begin
                    state <= TX_STOP;
                end
            end
            TX_STOP: begin
                sd_cmd_out <= 1'b1;
                state      <= TX_ACK;
            end
            TX_ACK: begin
                // Line released in the same cycle that ack rises
                sd_cmd_oe  <= 1'b0;
                sd_cmd_out <= 1'b0;
                xfer.ack   <= 1'b1;
                if (xfer.ack && !xfer.req) begin
                    xfer.ack <= 1'b0;
                    state    <= TX_IDLE;
                end
            end
            default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

/* sd_resp_receiver.sv */
`timescale 1ns/10ps

module sd_resp_receiver import sd_cmd_pkg::*; (
    input  logic      clk_fast,
    input  logic      init_resetPulse,
    sd_xfer_if.engine xfer,
    input  logic      sd_cmd_in
);

    rx_state_t  state;
    bit_count_t cnt;
    cmd_word_t  shift_q;
    crc7_t      crc;
    logic       err_q;
    logic       start_seen;
    logic       crc_enable;

    assign start_seen = (state == RX_HUNT) && !sd_cmd_in;

    // Start bit plus the next 39 bits feed the CRC
    assign crc_enable = start_seen ||
                        ((state == RX_SHIFT) && (cnt < bit_count_t'(PAYLOAD_BITS)));

    assign xfer.word = shift_q;
    assign xfer.err  = err_q;

    sd_crc7 crc_i (
        .clk_fast (clk_fast),
        .clear    (state == RX_IDLE),
        .enable   (crc_enable),
        .data_bit (sd_cmd_in),
        .crc      (crc)
    );

    // Frame shifter, held once the ACK state is reached
    always_ff @(posedge clk_fast) begin
        if (start_seen || state == RX_SHIFT) begin
            shift_q <= {shift_q[CMD_BITS-2:0], sd_cmd_in};
        end
    end

    // ==================================================
    // Receive FSM
    // ==================================================
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state    <= RX_IDLE;
            cnt      <= '0;
            err_q    <= 1'b0;
            xfer.ack <= 1'b0;
        end else begin
            case (state)
            RX_IDLE: begin
                if (xfer.req) begin
                    cnt   <= '0;
                    state <= RX_TURN;
                end
            end
            RX_TURN: begin
                // Card may still be fighting the released line here
                cnt <= cnt + bit_count_t'(1);
                if (cnt == bit_count_t'(TURNAROUND_CYCLES - 1)) begin
                    state <= RX_HUNT;
                end
            end
            RX_HUNT: begin
                // No time limit on the start bit
                if (start_seen) begin
                    cnt   <= bit_count_t'(1);
                    state <= RX_SHIFT;
                end
            end
            RX_SHIFT: begin
                cnt <= cnt + bit_count_t'(1);
                if (cnt == bit_count_t'(CMD_BITS - 1)) begin
                    state <= RX_ACK;
                end
            end
            RX_ACK: begin
                // CRC sits in bits 7:1, end bit in bit 0
                err_q    <= (shift_q[CRC_BITS:1] != crc) || !shift_q[0];
                xfer.ack <= 1'b1;
                if (xfer.ack && !xfer.req) begin
                    xfer.ack <= 1'b0;
                    state    <= RX_IDLE;
                end
            end
            default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

/* sd_cmd_sequencer.sv */
`timescale 1ns/10ps

module sd_cmd_sequencer import sd_cmd_pkg::*; (
    input  logic         clk_fast,
    input  logic         init_resetPulse,
    input  logic         cmd_trigger,
    input  cmd_word_t    cmd_data,
    input  resp_type_t   cmd_resp_type,
    output logic         cmd_done,
    output logic         resp_done,
    output cmd_word_t    resp_data,
    output logic         resp_crc_err,
    sd_xfer_if.initiator tx,
    sd_xfer_if.initiator rx
);

    seq_state_t state;
    resp_type_t resp_type_q;
    cmd_word_t  cmd_q;
    logic       trigger_q;
    logic       trigger_change;

    // Toggles seen while busy are absorbed here and never acted on
    assign trigger_change = cmd_trigger ^ trigger_q;

    assign tx.word = cmd_q;

    always_ff @(posedge clk_fast) begin
        trigger_q <= cmd_trigger;
        if (state == SEQ_IDLE && trigger_change) begin
            cmd_q <= cmd_data;
        end
        if (state == SEQ_RECV && rx.ack) begin
            resp_data <= rx.word;
        end
    end

    // ==================================================
    // Toggle to four-phase bridge
    // ==================================================
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state        <= SEQ_IDLE;
            resp_type_q  <= RESP_NONE;
            tx.req       <= 1'b0;
            rx.req       <= 1'b0;
            cmd_done     <= 1'b0;
            resp_done    <= 1'b0;
            resp_crc_err <= 1'b0;
        end else begin
            case (state)
            SEQ_IDLE: begin
                if (trigger_change) begin
                    resp_type_q <= cmd_resp_type;
                    tx.req      <= 1'b1;
                    state       <= SEQ_SEND;
                end
            end
            SEQ_SEND: begin
                if (tx.ack) begin
                    tx.req   <= 1'b0;
                    cmd_done <= ~cmd_done;
                    // Start the receiver now so it is hunting before the card replies
                    rx.req   <= (resp_type_q == RESP_48);
                    state    <= SEQ_SEND_DROP;
                end
            end
            SEQ_SEND_DROP: begin
                if (!tx.ack) begin
                    state <= (resp_type_q == RESP_48) ? SEQ_RECV : SEQ_IDLE;
                end
            end
            SEQ_RECV: begin
                if (rx.ack) begin
                    rx.req       <= 1'b0;
                    resp_crc_err <= rx.err;
                    resp_done    <= ~resp_done;
                    state        <= SEQ_RECV_DROP;
                end
            end
            SEQ_RECV_DROP: begin
                if (!rx.ack) begin
                    state <= SEQ_IDLE;
                end
            end
            default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

/* sd_cmd_controller.sv */
`timescale 1ns/10ps

module sd_cmd_controller import sd_cmd_pkg::*; (
    input  logic       clk_fast,
    input  logic       init_resetPulse,

    // Command side, toggle signalling
    input  logic       cmd_trigger,
    input  cmd_word_t  cmd_data,
    input  resp_type_t cmd_resp_type,
    output logic       cmd_done,

    // Response side
    output logic       resp_done,
    output cmd_word_t  resp_data,
    output logic       resp_crc_err,

    // Split CMD pin
    output logic       sd_cmd_out,
    output logic       sd_cmd_oe,
    input  logic       sd_cmd_in
);

    sd_xfer_if tx_bus ();
    sd_xfer_if rx_bus ();

    sd_cmd_sequencer seq_i (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .cmd_trigger     (cmd_trigger),
        .cmd_data        (cmd_data),
        .cmd_resp_type   (cmd_resp_type),
        .cmd_done        (cmd_done),
        .resp_done       (resp_done),
        .resp_data       (resp_data),
        .resp_crc_err    (resp_crc_err),
        .tx              (tx_bus.initiator),
        .rx              (rx_bus.initiator)
    );

    // Sole owner of the CMD output and its enable
    sd_cmd_sender tx_i (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .xfer            (tx_bus.engine),
        .sd_cmd_out      (sd_cmd_out),
        .sd_cmd_oe       (sd_cmd_oe)
    );

    sd_resp_receiver rx_i (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .xfer            (rx_bus.engine),
        .sd_cmd_in       (sd_cmd_in)
    );

endmodule

/* sd_cmd_controller_checker.sv */
`timescale 1ns/10ps

module sd_cmd_controller_checker (
    input logic clk_fast,
    input logic init_resetPulse,
    input logic sd_cmd_oe,
    input logic sd_cmd_out
);

    // Consecutive cycles with the line driven
    logic [6:0] high_cnt;

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse || !sd_cmd_oe) begin
            high_cnt <= '0;
        end else begin
            high_cnt <= high_cnt + 7'd1;
        end
    end

    // ==================================================
    // CMD line rules
    // ==================================================
    oe_low_in_reset: assert property (@(posedge clk_fast)
        init_resetPulse |=> !sd_cmd_oe)
        else $error("sd_cmd_oe driven during reset");

    oe_not_too_long: assert property (@(posedge clk_fast) disable iff (init_resetPulse)
        sd_cmd_oe |-> (high_cnt < 7'd48))
        else $error("sd_cmd_oe high for more than 48 cycles");

    oe_not_too_short: assert property (@(posedge clk_fast) disable iff (init_resetPulse)
        $fell(sd_cmd_oe) |-> (high_cnt == 7'd48))
        else $error("sd_cmd_oe high for fewer than 48 cycles");

    stop_bit_high: assert property (@(posedge clk_fast) disable iff (init_resetPulse)
        (sd_cmd_oe && high_cnt == 7'd47) |-> sd_cmd_out)
        else $error("stop bit of the command is not 1");

endmodule

bind sd_cmd_controller sd_cmd_controller_checker chk_i (
    .clk_fast        (clk_fast),
    .init_resetPulse (init_resetPulse),
    .sd_cmd_oe       (sd_cmd_oe),
    .sd_cmd_out      (sd_cmd_out)
);

/* tb_sd_cmd_controller.sv */
`timescale 1ns/10ps

module tb_sd_cmd_controller import sd_cmd_pkg::*; ();

    // Receiver starts hunting two cycles after its turnaround has begun
    localparam int REPLY_GAP = TURNAROUND_CYCLES + 2;

    logic       clk_fast = 1'b0;
    logic       init_resetPulse;
    logic       cmd_trigger;
    cmd_word_t  cmd_data;
    resp_type_t cmd_resp_type;
    logic       cmd_done;
    logic       resp_done;
    cmd_word_t  resp_data;
    logic       resp_crc_err;
    logic       sd_cmd_out;
    logic       sd_cmd_oe;
    logic       sd_cmd_in;

    cmd_word_t   stim_cmd[$];
    int          stim_type[$];
    logic [39:0] stim_payload[$];
    int          stim_fault[$];

    int          errors = 0;
    int          cycles = 0;
    int          limit = 1000000;
    logic [31:0] lfsr = 32'h2776_6475;
    logic        cmd_done_exp = 1'b0;
    logic        resp_done_exp = 1'b0;

    sd_cmd_controller dut_i (.*);

    always #2 clk_fast = ~clk_fast;

    always @(posedge clk_fast) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ==================================================
    // Reference models
    // ==================================================
    function automatic crc7_t crc7_of(input logic [39:0] bits);
        crc7_t c;
        logic  fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = c[6] ^ bits[i];
            c  = {c[5:0], 1'b0};
            if (fb) c = c ^ 7'h09;
        end
        return c;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'hA300_0000;
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
        errors++;
    endtask

    // ==================================================
    // One command, plus the card's reply when requested
    // ==================================================
    task automatic run_test(input int idx);
        cmd_word_t sent;
        cmd_word_t expect_frame;
        cmd_word_t reply;
        crc7_t     reply_crc;
        int        gap;
        logic      done_early;
        logic      oe_short;
        string     name;
        name         = $sformatf("test %0d", idx);
        expect_frame = {stim_cmd[idx][47:8], crc7_of(stim_cmd[idx][47:8]), 1'b1};
        reply_crc    = crc7_of(stim_payload[idx]);
        if (stim_fault[idx] == 1) reply_crc[0] = ~reply_crc[0];
        reply = {stim_payload[idx], reply_crc, (stim_fault[idx] != 2)};

        if (resp_done != resp_done_exp) begin
            report_mismatch({name, " stray resp_done"}, 64'(resp_done_exp), 64'(resp_done));
        end
        cmd_data      = stim_cmd[idx];
        cmd_resp_type = resp_type_t'(stim_type[idx] != 0);
        cmd_trigger   = ~cmd_trigger;
        @(negedge clk_fast);
        while (!sd_cmd_oe) @(negedge clk_fast);

        // Card side capture of the command frame
        done_early = 1'b0;
        oe_short   = 1'b0;
        for (int i = CMD_BITS - 1; i >= 0; i--) begin
            if (!sd_cmd_oe) oe_short = 1'b1;
            if (cmd_done != cmd_done_exp) done_early = 1'b1;
            sent[i] = sd_cmd_out;
            @(negedge clk_fast);
        end
        if (oe_short) $display("[ERROR] %s: sd_cmd_oe dropped inside the frame", name);
        if (oe_short) errors++;
        if (sd_cmd_oe) $display("[ERROR] %s: sd_cmd_oe held past 48 cycles", name);
        if (sd_cmd_oe) errors++;
        if (done_early) $display("[ERROR] %s: cmd_done toggled while sending", name);
        if (done_early) errors++;
        if (sent !== expect_frame) begin
            report_mismatch({name, " cmd frame"}, 64'(expect_frame), 64'(sent));
        end
        cmd_done_exp = ~cmd_done_exp;

        if (stim_type[idx] != 0) begin
            take_bits(3, gap);
            repeat (REPLY_GAP + gap) @(negedge clk_fast);
            for (int i = CMD_BITS - 1; i >= 0; i--) begin
                sd_cmd_in = reply[i];
                @(negedge clk_fast);
            end
            sd_cmd_in = 1'b1;
            while (resp_done == resp_done_exp) @(negedge clk_fast);
            resp_done_exp = ~resp_done_exp;
            if (resp_data !== reply) begin
                report_mismatch({name, " resp_data"}, 64'(reply), 64'(resp_data));
            end
            if (resp_crc_err !== (stim_fault[idx] != 0)) begin
                report_mismatch({name, " resp_crc_err"}, 64'(stim_fault[idx] != 0),
                                64'(resp_crc_err));
            end
        end else begin
            while (cmd_done != cmd_done_exp) @(negedge clk_fast);
        end
        // Let the sequencer settle back to idle
        repeat (4) @(negedge clk_fast);
        // A second toggle by now would leave cmd_done off its expected level
        if (cmd_done !== cmd_done_exp) begin
            report_mismatch({name, " cmd_done"}, 64'(cmd_done_exp), 64'(cmd_done));
        end
    endtask

    initial begin
        int          fd;
        int          rc;
        string       line;
        cmd_word_t   w;
        int          t;
        logic [39:0] p;
        int          f;
        init_resetPulse = 1'b1;
        cmd_trigger     = 1'b0;
        cmd_data        = '0;
        cmd_resp_type   = RESP_NONE;
        sd_cmd_in       = 1'b1;

        fd = $fopen("sd_cmd_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sd_cmd_stim.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc   = $fgets(line, fd);
                if (rc != 0 && line.len() > 1 && line.getc(0) != "#") begin
                    rc = $sscanf(line, "%h %d %h %d", w, t, p, f);
                    if (rc == 4) begin
                        stim_cmd.push_back(w);
                        stim_type.push_back(t);
                        stim_payload.push_back(p);
                        stim_fault.push_back(f);
                    end
                end
            end
            $fclose(fd);
        end
        limit = 300 * stim_cmd.size() + 50;

        repeat (3) @(negedge clk_fast);
        init_resetPulse = 1'b0;
        if ({sd_cmd_oe, sd_cmd_out, cmd_done, resp_done, resp_crc_err} !== 5'b0) begin
            report_mismatch("reset outputs", 64'(0),
                            64'({sd_cmd_oe, sd_cmd_out, cmd_done, resp_done, resp_crc_err}));
        end

        for (int i = 0; i < stim_cmd.size(); i++) begin
            run_test(i);
        end

        $display("Summary: %0d tests run, %0d errors", stim_cmd.size(), errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* sd_cmd_stim.txt */
# cmd_word(hex 48b) resp_type(0 none, 1 r48) resp_payload(hex 40b) fault(0 none, 1 crc, 2 end)
# low byte of cmd_word is replaced by the controller with CRC7 and stop bit
400000000000 0 0000000000 0
48000001AA00 1 08000001AA 0
770000000000 1 3700000120 0
6940FF800000 1 3F00FF8000 1
430000000000 1 03AAAA0520 0
470001000000 0 0000000000 0
4D0001000000 1 0D00000900 2
500000020000 1 1000000900 0
510000000000 1 1100000900 1
580000000000 0 0000000000 0
4C0000000000 1 0C00000B00 0
7A5A5A5A5AFF 1 3A5A5A5A5A 2

/* sd_cmd_controller.f */
sd_cmd_pkg.sv
sd_xfer_if.sv
sd_crc7.sv
sd_cmd_sender.sv
sd_resp_receiver.sv
sd_cmd_sequencer.sv
sd_cmd_controller.sv
sd_cmd_controller_checker.sv
tb_sd_cmd_controller.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the SD CMD controller testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f sd_cmd_controller.f \
    --top-module tb_sd_cmd_controller -o tb_sd_cmd_controller
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sd_cmd_controller > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0
